/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --assert -j 0
TOP       := xbar_tb
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(filter %.sv,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf $(OBJ_DIR)

/* dv/xbar_properties.sv */
/* Handshake assertions on the crossbar ports, bound to the top level by the testbench.
   Violations show up as assertion errors in the simulation log. */
`timescale 1ns/10ps

module xbar_properties
  import xbar_pkg::*;
(
  input logic      clk_i,
  input logic      arst_n_i,
  input logic      init_req_valid_i [NUM_INIT],
  input xbar_req_t init_req_i       [NUM_INIT],
  input logic      init_req_ready_i [NUM_INIT],
  input logic      init_rsp_valid_i [NUM_INIT],
  input xbar_rsp_t init_rsp_i       [NUM_INIT],
  input logic      init_rsp_ready_i [NUM_INIT],
  input logic      tgt_req_valid_i  [NUM_TGT],
  input xbar_req_t tgt_req_i        [NUM_TGT],
  input logic      tgt_req_ready_i  [NUM_TGT]
);

  int assert_fail_cnt = 0; // Read by the testbench at the end of the run

  for (genvar i = 0; i < NUM_INIT; i++) begin : gen_init
    // A stalled beat keeps its valid and payload
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
      init_req_valid_i[i] && !init_req_ready_i[i]
      |=> init_req_valid_i[i] && $stable(init_req_i[i]))
      else begin
        $error("Initiator %0d request changed while stalled", i);
        assert_fail_cnt++;
      end
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
      init_rsp_valid_i[i] && !init_rsp_ready_i[i]
      |=> init_rsp_valid_i[i] && $stable(init_rsp_i[i]))
      else begin
        $error("Initiator %0d response changed while stalled", i);
        assert_fail_cnt++;
      end
    assert property (@(posedge clk_i) !arst_n_i |-> !init_rsp_valid_i[i] && !init_req_ready_i[i])
      else begin
        $error("Initiator %0d handshake active in reset", i);
        assert_fail_cnt++;
      end
  end

  for (genvar t = 0; t < NUM_TGT; t++) begin : gen_tgt
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
      tgt_req_valid_i[t] && !tgt_req_ready_i[t]
      |=> tgt_req_valid_i[t] && $stable(tgt_req_i[t]))
      else begin
        $error("Target %0d request changed while stalled", t);
        assert_fail_cnt++;
      end
    assert property (@(posedge clk_i) !arst_n_i |-> !tgt_req_valid_i[t])
      else begin
        $error("Target %0d request valid in reset", t);
        assert_fail_cnt++;
      end
  end

endmodule

/* dv/xbar_tb.sv */
/* Random-stimulus testbench for the crossbar, with memory models on the target ports
   and a reference memory per initiator address range. */
`timescale 1ns/10ps

module xbar_tb
  import xbar_pkg::*;
();

  localparam int N_XFER      = 150; // Transfers per initiator
  localparam int TIMEOUT_CYC = 40 * N_XFER * NUM_INIT + 200;

  logic      clk_i = 1'b0;
  logic      arst_n_i;
  logic      init_req_valid [NUM_INIT];
  xbar_req_t init_req       [NUM_INIT];
  logic      init_req_ready [NUM_INIT];
  logic      init_rsp_valid [NUM_INIT];
  xbar_rsp_t init_rsp       [NUM_INIT];
  logic      init_rsp_ready [NUM_INIT];
  logic      tgt_req_valid  [NUM_TGT];
  xbar_req_t tgt_req        [NUM_TGT];
  logic      tgt_req_ready  [NUM_TGT];
  logic      tgt_rsp_valid  [NUM_TGT];
  xbar_rsp_t tgt_rsp        [NUM_TGT];
  logic      tgt_rsp_ready  [NUM_TGT];

  // Per-initiator transfer in flight, as seen by the model
  xbar_req_t         pend_req  [NUM_INIT];
  int                pend_tgt  [NUM_INIT]; // NUM_TGT marks a decode error
  int                pend_seen [NUM_INIT];
  logic              waiting   [NUM_INIT];
  int                wait_cnt  [NUM_INIT];
  int                req_cnt   [NUM_INIT];
  int                rsp_cnt   [NUM_INIT];
  logic [DATA_W-1:0] ref_mem [logic [ADDR_W-1:0]];
  logic [DATA_W-1:0] tgt_mem [logic [ADDR_W-1:0]]; // Storage behind the target ports
  bit   [31:0]       lcg_state = 32'd74712;
  int                cycle = 0;
  int                mismatch_cnt = 0;
  int                other_cnt = 0;

  xbar_top u_xbar_top (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .init_req_valid_i (init_req_valid),
    .init_req_i       (init_req),
    .init_req_ready_o (init_req_ready),
    .init_rsp_valid_o (init_rsp_valid),
    .init_rsp_o       (init_rsp),
    .init_rsp_ready_i (init_rsp_ready),
    .tgt_req_valid_o  (tgt_req_valid),
    .tgt_req_o        (tgt_req),
    .tgt_req_ready_i  (tgt_req_ready),
    .tgt_rsp_valid_i  (tgt_rsp_valid),
    .tgt_rsp_i        (tgt_rsp),
    .tgt_rsp_ready_o  (tgt_rsp_ready)
  );

  bind xbar_top xbar_properties u_xbar_properties (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .init_req_valid_i (init_req_valid_i),
    .init_req_i       (init_req_i),
    .init_req_ready_i (init_req_ready_o),
    .init_rsp_valid_i (init_rsp_valid_o),
    .init_rsp_i       (init_rsp_o),
    .init_rsp_ready_i (init_rsp_ready_i),
    .tgt_req_valid_i  (tgt_req_valid_o),
    .tgt_req_i        (tgt_req_o),
    .tgt_req_ready_i  (tgt_req_ready_i)
  );

  always #2 clk_i = ~clk_i;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return {lcg_state[7:0], lcg_state[31:8]}; // Weak low bits moved to the top
  endfunction

  // Region mix of 3:2:2 over the targets and 1 in 8 unmapped
  function automatic xbar_req_t make_request(input init_idx_t owner, output int tgt);
    xbar_req_t   req;
    logic [31:0] r;
    r = lcg_next() % 8;
    if (r < 3) tgt = 0;
    else if (r < 5) tgt = 1;
    else if (r < 7) tgt = 2;
    else tgt = NUM_TGT;
    if (tgt < NUM_TGT) req.addr = TGT_BASE[tgt];
    else req.addr = (lcg_next() % 2 == 0) ? 16'h2000 : 16'hC000;
    req.addr[11]  = owner; // Address bit 11 names the initiator
    req.addr[5:2] = 4'(lcg_next());
    req.we        = (lcg_next() % 2) == 1;
    req.wdata     = lcg_next();
    return req;
  endfunction

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
      mismatch_cnt++;
    end
  endtask

  always @(posedge clk_i) begin
    cycle <= cycle + 1;
    if (cycle >= TIMEOUT_CYC) begin
      $display("Timeout after %0d cycles, transfers still in flight", cycle);
      $display("Errors: %0d mismatches, %0d other failures, %0d assertion failures",
               mismatch_cnt, other_cnt, u_xbar_top.u_xbar_properties.assert_fail_cnt);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  // Handshake counters on the initiator ports
  always @(negedge clk_i) begin
    for (int i = 0; i < NUM_INIT; i++) begin
      if (init_req_valid[i] && init_req_ready[i]) req_cnt[i]++;
      if (init_rsp_valid[i] && init_rsp_ready[i]) rsp_cnt[i]++;
    end
  end

  task automatic note_target_request(input int t, input xbar_req_t req);
    init_idx_t owner;
    owner = req.addr[11];
    check_val("tgt_req_o.addr", 64'(req.addr), 64'(pend_req[owner].addr));
    check_val("tgt_req_o.we", 64'(req.we), 64'(pend_req[owner].we));
    check_val("tgt_req_o.wdata", 64'(req.wdata), 64'(pend_req[owner].wdata));
    check_val("tgt_req_valid_o index", 64'(t), 64'(pend_tgt[owner]));
    pend_seen[owner]++;
    for (int k = 0; k < NUM_INIT; k++) begin
      if (k != int'(owner) && waiting[k] && pend_tgt[k] == t) wait_cnt[k]++;
    end
  endtask

  task automatic serve_target(input int t);
    xbar_req_t req;
    forever begin
      tgt_req_ready[t] = (lcg_next() % 4) != 0;
      @(negedge clk_i);
      if (tgt_req_valid[t] && tgt_req_ready[t]) begin
        req = tgt_req[t];
        note_target_request(t, req);
        @(posedge clk_i);
        #1;
        tgt_req_ready[t] = 1'b0;
        repeat (lcg_next() % 4) begin
          @(posedge clk_i);
          #1;
        end
        tgt_rsp[t].err   = 1'b0;
        tgt_rsp[t].rdata = (!req.we && tgt_mem.exists(req.addr)) ? tgt_mem[req.addr] : '0;
        if (req.we) tgt_mem[req.addr] = req.wdata;
        tgt_rsp_valid[t] = 1'b1;
        @(negedge clk_i);
        while (!tgt_rsp_ready[t]) @(negedge clk_i);
      end
      @(posedge clk_i);
      #1;
      tgt_rsp_valid[t] = 1'b0;
    end
  endtask

  task automatic run_initiator(input int i);
    xbar_req_t         req;
    xbar_rsp_t         rsp;
    logic [DATA_W-1:0] exp_rdata;
    int                acc_cyc;
    int                first_cyc;
    logic              done;
    for (int n = 0; n < N_XFER; n++) begin
      repeat (lcg_next() % 4) begin
        @(posedge clk_i);
        #1;
      end
      req          = make_request(init_idx_t'(i), pend_tgt[i]);
      pend_req[i]  = req;
      pend_seen[i] = 0;
      wait_cnt[i]  = 0;
      waiting[i]   = 1'b1;
      init_req[i]       = req;
      init_req_valid[i] = 1'b1;
      @(negedge clk_i);
      while (!init_req_ready[i]) @(negedge clk_i);
      acc_cyc    = cycle;
      waiting[i] = 1'b0;
      check_val("init_rsp_valid_o at acceptance", 64'(init_rsp_valid[i]), 64'd0);
      if (wait_cnt[i] > NUM_INIT) begin
        $display("Initiator %0d waited behind %0d transfers at target %0d",
                 i, wait_cnt[i], pend_tgt[i]);
        other_cnt++;
      end
      // Addresses are private per initiator, so acceptance order fixes the read value
      exp_rdata = '0;
      if (pend_tgt[i] != NUM_TGT && req.we) begin
        ref_mem[req.addr] = req.wdata;
      end else if (pend_tgt[i] != NUM_TGT && ref_mem.exists(req.addr)) begin
        exp_rdata = ref_mem[req.addr];
      end
      @(posedge clk_i);
      #1;
      init_req_valid[i] = 1'b0;
      first_cyc = -1;
      done      = 1'b0;
      while (!done) begin
        init_rsp_ready[i] = (lcg_next() % 3) != 0;
        @(negedge clk_i);
        if (init_rsp_valid[i] && first_cyc < 0) first_cyc = cycle;
        done = init_rsp_valid[i] && init_rsp_ready[i];
        rsp  = init_rsp[i];
        @(posedge clk_i);
        #1;
      end
      init_rsp_ready[i] = 1'b0;
      check_val("init_rsp_o.err", 64'(rsp.err), 64'(pend_tgt[i] == NUM_TGT));
      check_val("init_rsp_o.rdata", 64'(rsp.rdata), 64'(exp_rdata));
      check_val("tgt_req_valid_o count", 64'(pend_seen[i]),
                (pend_tgt[i] == NUM_TGT) ? 64'd0 : 64'd1);
      if (pend_tgt[i] == NUM_TGT) begin
        check_val("init_rsp_valid_o delay", 64'(first_cyc - acc_cyc), 64'd1);
      end
    end
  endtask

  initial begin
    arst_n_i = 1'b0;
    for (int i = 0; i < NUM_INIT; i++) begin
      init_req_valid[i] = 1'b0;
      init_req[i]       = '0;
      init_rsp_ready[i] = 1'b0;
      waiting[i]        = 1'b0;
      req_cnt[i]        = 0;
      rsp_cnt[i]        = 0;
    end
    for (int t = 0; t < NUM_TGT; t++) begin
      tgt_req_ready[t] = 1'b0;
      tgt_rsp_valid[t] = 1'b0;
      tgt_rsp[t]       = '0;
    end
    repeat (2) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;
    fork
      serve_target(0);
      serve_target(1);
      serve_target(2);
    join_none
    fork
      run_initiator(0);
      run_initiator(1);
    join
    for (int i = 0; i < NUM_INIT; i++) begin
      init_rsp_ready[i] = 1'b1; // Any extra response is taken and counted
    end
    repeat (8) @(posedge clk_i); // Room for stray responses to show up
    for (int i = 0; i < NUM_INIT; i++) begin
      check_val("init_rsp_valid_o count", 64'(rsp_cnt[i]), 64'(req_cnt[i]));
    end
    $display("Errors: %0d mismatches, %0d other failures, %0d assertion failures",
             mismatch_cnt, other_cnt, u_xbar_top.u_xbar_properties.assert_fail_cnt);
    if (mismatch_cnt == 0 && other_cnt == 0 &&
        u_xbar_top.u_xbar_properties.assert_fail_cnt == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

/* logic/xbar_init_demux.sv */
/* Initiator-side request demultiplexer with a built-in decode-error responder.
   Decodes each request against the package map and returns the chosen target's response. */
`timescale 1ns/10ps

module xbar_init_demux
  import xbar_pkg::*;
(
  input  logic      clk_i,
  input  logic      arst_n_i,
  // Initiator port
  input  logic      req_valid_i,
  input  xbar_req_t req_i,
  output logic      req_ready_o,
  output logic      rsp_valid_o,
  output xbar_rsp_t rsp_o,
  input  logic      rsp_ready_i,
  // Toward the target multiplexers
  output logic      tgt_req_valid_o [NUM_TGT],
  output xbar_req_t tgt_req_o,
  input  logic      tgt_req_ready_i [NUM_TGT],
  input  logic      tgt_rsp_valid_i [NUM_TGT],
  input  xbar_rsp_t tgt_rsp_i       [NUM_TGT],
  output logic      tgt_rsp_ready_o [NUM_TGT]
);

  tgt_sel_t dec_sel; // Decode of the current request
  tgt_sel_t sel_q;   // Target of the outstanding transfer
  logic     busy_q;
  logic     tgt_ready;
  logic     req_hs;
  logic     rsp_hs;

  // Address decode, no hit selects the error responder
  always_comb begin
    for (int t = 0; t < NUM_TGT; t++) begin
      dec_sel[t] = (req_i.addr & TGT_MASK[t]) == TGT_BASE[t];
    end
    dec_sel[NUM_TGT] = ~|dec_sel[NUM_TGT-1:0];
  end

  // Request steering
  always_comb begin
    tgt_ready = dec_sel[NUM_TGT]; // Error responder is always ready
    for (int t = 0; t < NUM_TGT; t++) begin
      tgt_req_valid_o[t] = req_valid_i & ~busy_q & dec_sel[t];
      tgt_ready          = tgt_ready | (dec_sel[t] & tgt_req_ready_i[t]);
    end
  end

  assign req_ready_o = req_valid_i & ~busy_q & tgt_ready;
  assign tgt_req_o   = req_i; // Payload is shared, only the valids are steered
  assign req_hs      = req_valid_i & req_ready_o;

  // Response return from the registered select
  always_comb begin
    rsp_valid_o = busy_q & sel_q[NUM_TGT]; // Error answer one cycle after acceptance
    rsp_o       = xbar_rsp_t'{rdata: '0, err: 1'b1};
    for (int t = 0; t < NUM_TGT; t++) begin
      tgt_rsp_ready_o[t] = busy_q & sel_q[t] & rsp_ready_i;
      if (sel_q[t]) begin
        rsp_valid_o = busy_q & tgt_rsp_valid_i[t];
        rsp_o       = tgt_rsp_i[t];
      end
    end
  end

  assign rsp_hs = rsp_valid_o & rsp_ready_i;

  // One outstanding transfer, set on acceptance and cleared on the response
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q <= 1'b0;
      sel_q  <= '0;
    end else if (req_hs) begin
      busy_q <= 1'b1;
      sel_q  <= dec_sel;
    end else if (rsp_hs) begin
      busy_q <= 1'b0;
    end
  end

endmodule

/* logic/xbar_pkg.sv */
/* Shared widths, port counts, address map and payload structs of the crossbar.
   Imported by every crossbar module and by the testbench. */
package xbar_pkg;

  // Port counts
  localparam int NUM_INIT = 2;
  localparam int NUM_TGT  = 3;

  // Bus widths
  localparam int ADDR_W = 16;
  localparam int DATA_W = 32;

  localparam int INIT_IDX_W = 1; // Wide enough to index NUM_INIT initiators

  // Fixed address map, entry t belongs to target t
  // A request hits target t when (addr & TGT_MASK[t]) == TGT_BASE[t]
  localparam logic [NUM_TGT-1:0][ADDR_W-1:0] TGT_BASE = {
    16'h4000, // Target 2
    16'h1000, // Target 1
    16'h0000  // Target 0
  };
  localparam logic [NUM_TGT-1:0][ADDR_W-1:0] TGT_MASK = {
    16'hF000,
    16'hF000,
    16'hF000
  };

  typedef logic [INIT_IDX_W-1:0] init_idx_t;

  // One-hot target select, bit NUM_TGT is the decode-error responder
  typedef logic [NUM_TGT:0] tgt_sel_t;

  // Request channel
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              we;    // High for a write
    logic [DATA_W-1:0] wdata;
  } xbar_req_t;

  // Response channel
  typedef struct packed {
    logic [DATA_W-1:0] rdata; // Zero on writes and on decode errors
    logic              err;
  } xbar_rsp_t;

endpackage

/* logic/xbar_spill_reg.sv */
/* One-entry registered valid/ready stage for any payload type.
   Cuts the valid and data paths between two handshake interfaces. */
`timescale 1ns/10ps

module xbar_spill_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     arst_n_i,
  // Upstream side
  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t data_i,
  // Downstream side
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o
);

  logic     valid_q;
  payload_t data_q;

  // Room when empty or when the held entry leaves this cycle
  assign ready_o = ~valid_q | ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  // Payload only loads on an accepted beat
  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      data_q <= data_i;
    end
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

endmodule

/* logic/xbar_tgt_mux.sv */
/* Target-side multiplexer with a round-robin arbiter that locks its grant per transfer.
   Spill registers sit on the request and the response side of the target port. */
`timescale 1ns/10ps

module xbar_tgt_mux
  import xbar_pkg::*;
(
  input  logic      clk_i,
  input  logic      arst_n_i,
  // From the initiator demultiplexers
  input  logic      init_req_valid_i [NUM_INIT],
  input  xbar_req_t init_req_i       [NUM_INIT],
  output logic      init_req_ready_o [NUM_INIT],
  output logic      init_rsp_valid_o [NUM_INIT],
  output xbar_rsp_t init_rsp_o,
  input  logic      init_rsp_ready_i [NUM_INIT],
  // Target port
  output logic      req_valid_o,
  output xbar_req_t req_o,
  input  logic      req_ready_i,
  input  logic      rsp_valid_i,
  input  xbar_rsp_t rsp_i,
  output logic      rsp_ready_o
);

  init_idx_t rr_ptr_q;  // Highest priority in the next round
  init_idx_t gnt_q;     // Owner of the locked transfer
  init_idx_t arb_idx;
  logic      arb_found;
  logic      locked_q;
  logic      req_spill_ready;
  logic      req_hs;
  logic      rsp_spill_valid;
  logic      rsp_spill_ready;
  logic      release_hs;

  // Round-robin search starting at rr_ptr_q
  always_comb begin
    int cand;
    arb_found = 1'b0;
    arb_idx   = rr_ptr_q;
    for (int k = 0; k < NUM_INIT; k++) begin
      cand = (int'(rr_ptr_q) + k) % NUM_INIT;
      if (!arb_found && init_req_valid_i[cand]) begin
        arb_found = 1'b1;
        arb_idx   = init_idx_t'(cand);
      end
    end
  end

  assign req_hs = ~locked_q & arb_found & req_spill_ready;

  always_comb begin
    for (int i = 0; i < NUM_INIT; i++) begin
      init_req_ready_o[i] = req_hs & (arb_idx == init_idx_t'(i));
      init_rsp_valid_o[i] = rsp_spill_valid & (gnt_q == init_idx_t'(i));
    end
  end

  xbar_spill_reg #(.payload_t(xbar_req_t)) u_req_spill (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .valid_i  (~locked_q & arb_found),
    .ready_o  (req_spill_ready),
    .data_i   (init_req_i[arb_idx]),
    .valid_o  (req_valid_o),
    .ready_i  (req_ready_i),
    .data_o   (req_o)
  );

  // Responses are only taken while a transfer is locked
  assign rsp_ready_o = locked_q & rsp_spill_ready;

  xbar_spill_reg #(.payload_t(xbar_rsp_t)) u_rsp_spill (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .valid_i  (locked_q & rsp_valid_i),
    .ready_o  (rsp_spill_ready),
    .data_i   (rsp_i),
    .valid_o  (rsp_spill_valid),
    .ready_i  (init_rsp_ready_i[gnt_q]),
    .data_o   (init_rsp_o)
  );

  assign release_hs = rsp_spill_valid & init_rsp_ready_i[gnt_q];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      locked_q <= 1'b0;
      gnt_q    <= '0;
      rr_ptr_q <= '0;
    end else if (req_hs) begin
      locked_q <= 1'b1;
      gnt_q    <= arb_idx;
      rr_ptr_q <= (arb_idx == init_idx_t'(NUM_INIT - 1)) ? '0 : init_idx_t'(arb_idx + 1'b1);
    end else if (release_hs) begin
      locked_q <= 1'b0; // Grant held until the owner takes the response
    end
  end

endmodule

/* logic/xbar_top.sv */
/* Crossbar top level, NUM_INIT initiator ports fully crossed to NUM_TGT target ports.
   Each initiator gets a demultiplexer and each target a multiplexer. */
`timescale 1ns/10ps

module xbar_top
  import xbar_pkg::*;
(
  input  logic      clk_i,
  input  logic      arst_n_i,
  // Initiator ports
  input  logic      init_req_valid_i [NUM_INIT],
  input  xbar_req_t init_req_i       [NUM_INIT],
  output logic      init_req_ready_o [NUM_INIT],
  output logic      init_rsp_valid_o [NUM_INIT],
  output xbar_rsp_t init_rsp_o       [NUM_INIT],
  input  logic      init_rsp_ready_i [NUM_INIT],
  // Target ports
  output logic      tgt_req_valid_o  [NUM_TGT],
  output xbar_req_t tgt_req_o        [NUM_TGT],
  input  logic      tgt_req_ready_i  [NUM_TGT],
  input  logic      tgt_rsp_valid_i  [NUM_TGT],
  input  xbar_rsp_t tgt_rsp_i        [NUM_TGT],
  output logic      tgt_rsp_ready_o  [NUM_TGT]
);

  // Demux side, indexed [initiator][target]
  logic      dmx_req_valid [NUM_INIT][NUM_TGT];
  xbar_req_t dmx_req       [NUM_INIT];
  logic      dmx_req_ready [NUM_INIT][NUM_TGT];
  logic      dmx_rsp_valid [NUM_INIT][NUM_TGT];
  xbar_rsp_t dmx_rsp       [NUM_INIT][NUM_TGT];
  logic      dmx_rsp_ready [NUM_INIT][NUM_TGT];

  // Mux side, indexed [target][initiator]
  logic      mux_req_valid [NUM_TGT][NUM_INIT];
  xbar_req_t mux_req       [NUM_TGT][NUM_INIT];
  logic      mux_req_ready [NUM_TGT][NUM_INIT];
  logic      mux_rsp_valid [NUM_TGT][NUM_INIT];
  xbar_rsp_t mux_rsp       [NUM_TGT];
  logic      mux_rsp_ready [NUM_TGT][NUM_INIT];

  for (genvar i = 0; i < NUM_INIT; i++) begin : gen_init_demux
    xbar_init_demux u_init_demux (
      .clk_i           (clk_i),
      .arst_n_i        (arst_n_i),
      .req_valid_i     (init_req_valid_i[i]),
      .req_i           (init_req_i[i]),
      .req_ready_o     (init_req_ready_o[i]),
      .rsp_valid_o     (init_rsp_valid_o[i]),
      .rsp_o           (init_rsp_o[i]),
      .rsp_ready_i     (init_rsp_ready_i[i]),
      .tgt_req_valid_o (dmx_req_valid[i]),
      .tgt_req_o       (dmx_req[i]),
      .tgt_req_ready_i (dmx_req_ready[i]),
      .tgt_rsp_valid_i (dmx_rsp_valid[i]),
      .tgt_rsp_i       (dmx_rsp[i]),
      .tgt_rsp_ready_o (dmx_rsp_ready[i])
    );
  end

  // Transpose between the two sides
  for (genvar i = 0; i < NUM_INIT; i++) begin : gen_cross_init
    for (genvar t = 0; t < NUM_TGT; t++) begin : gen_cross_tgt
      assign mux_req_valid[t][i] = dmx_req_valid[i][t];
      assign mux_req[t][i]       = dmx_req[i];
      assign dmx_req_ready[i][t] = mux_req_ready[t][i];
      assign dmx_rsp_valid[i][t] = mux_rsp_valid[t][i];
      assign dmx_rsp[i][t]       = mux_rsp[t]; // Valid alone marks the owner
      assign mux_rsp_ready[t][i] = dmx_rsp_ready[i][t];
    end
  end

  for (genvar t = 0; t < NUM_TGT; t++) begin : gen_tgt_mux
    xbar_tgt_mux u_tgt_mux (
      .clk_i            (clk_i),
      .arst_n_i         (arst_n_i),
      .init_req_valid_i (mux_req_valid[t]),
      .init_req_i       (mux_req[t]),
      .init_req_ready_o (mux_req_ready[t]),
      .init_rsp_valid_o (mux_rsp_valid[t]),
      .init_rsp_o       (mux_rsp[t]),
      .init_rsp_ready_i (mux_rsp_ready[t]),
      .req_valid_o      (tgt_req_valid_o[t]),
      .req_o            (tgt_req_o[t]),
      .req_ready_i      (tgt_req_ready_i[t]),
      .rsp_valid_i      (tgt_rsp_valid_i[t]),
      .rsp_i            (tgt_rsp_i[t]),
      .rsp_ready_o      (tgt_rsp_ready_o[t])
    );
  end

endmodule

/* vlog.f */
logic/xbar_pkg.sv
logic/xbar_spill_reg.sv
logic/xbar_init_demux.sv
logic/xbar_tgt_mux.sv
logic/xbar_top.sv
dv/xbar_properties.sv
dv/xbar_tb.sv
